// ==== sim.f ====
hw/pixel_pkg.sv
hw/video_pkg.sv
hw/pixel_writer.sv
hw/frame_buffer.sv
hw/vga_scanout.sv
hw/mandel_display_top.sv
verif/tb_mandel_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mandel_display -f sim.f -o tb_mandel_display
result=$(./obj_dir/tb_mandel_display 2>&1) || true
printf '%s\n' "$result"
if printf '%s\n' "$result" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== verif/tb_mandel_display.sv ====
`timescale 1ns/1ps

module tb_mandel_display
	import pixel_pkg::*;
();

	// Small geometry, 23-cycle lines and 11-line frames
	localparam int H_PIXELS = 16;
	localparam int V_LINES = 8;
	localparam int NUM_BANKS = 4;
	localparam int BANK_DEPTH = 32;
	localparam int FRAME_PIXELS = 128;
	localparam int H_PERIOD = 23;
	localparam int TBL_SIZE = 16;

	// One stimulus row, count and its expected stored color
	typedef struct packed {
		iter_count_t count;
		logic [7:0] color;
	} stim_entry_t;

	// Counts at and around each threshold of MAX_ITER 100
	localparam stim_entry_t STIM_TBL [TBL_SIZE] = '{
		'{32'd0, 8'h52},
		'{32'd1, 8'h6A},
		'{32'd2, 8'h6A},
		'{32'd3, 8'h25},
		'{32'd5, 8'h25},
		'{32'd6, 8'h65},
		'{32'd11, 8'h65},
		'{32'd12, 8'hA9},
		'{32'd24, 8'hA9},
		'{32'd25, 8'h64},
		'{32'd49, 8'h64},
		'{32'd50, 8'h64},
		'{32'd99, 8'h64},
		'{32'd100, 8'h00},
		'{32'd101, 8'h00},
		'{32'hFFFF_FFFF, 8'h00}
	};

	logic clk;
	logic reset;
	iter_count_t iter_count [NUM_BANKS];
	logic [NUM_BANKS-1:0] iter_done;
	logic [NUM_BANKS-1:0] bank_all_done;
	logic [NUM_BANKS-1:0] handshake;
	logic hsync;
	logic vsync;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic active_video;

	// Table start per bank
	int unsigned bank_offset [NUM_BANKS];
	// Monitor state
	logic [23:0] frame_q [$];
	int hs_count [NUM_BANKS];
	logic [NUM_BANKS-1:0] handshake_prev = '0;
	logic act_prev = 1'b0;
	logic hsync_prev = 1'b1;
	logic vsync_prev = 1'b1;
	int cycle_cnt = 0;
	int act_run = 0;
	int hs_low = 0;
	int vs_low = 0;
	int lines_active = 0;
	int last_hfall = -1;
	int vs_rises = 0;

	mandel_display_top #(
		.H_PIXELS(H_PIXELS),
		.V_LINES(V_LINES),
		.H_FRONT(2),
		.H_PULSE(3),
		.H_BACK(2),
		.V_FRONT(1),
		.V_PULSE(1),
		.V_BACK(1),
		.NUM_BANKS(NUM_BANKS),
		.MAX_ITER(100)
	) i_dut (
		.M10k_pll(clk),
		.reset(reset),
		.iter_count(iter_count),
		.iter_done(iter_done),
		.bank_all_done(bank_all_done),
		.handshake(handshake),
		.hsync(hsync),
		.vsync(vsync),
		.red(red),
		.green(green),
		.blue(blue),
		.active_video(active_video)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at time %0t while waiting for %s", $time, what);
		$display("TESTBENCH FAILED");
		$fatal(1, "wait timed out");
	endtask

	// All banks accept together, so all pulse together
	task automatic wait_handshake();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > 20) begin
				report_timeout("a handshake pulse from every bank");
			end
		end while (handshake != '1);
	endtask

	task automatic wait_frame();
		int cycles;
		cycles = 0;
		while (frame_q.size() < FRAME_PIXELS || vs_rises == 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > 2000) begin
				report_timeout("a full captured frame and its vsync pulse");
			end
		end
	endtask

	////////////////////////////////////////
	// Monitor, samples mid-cycle
	////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			cycle_cnt++;
			// Single-cycle strobes only
			check_value("handshake repeat", handshake & handshake_prev, '0);
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (handshake[b]) hs_count[b]++;
			end
			handshake_prev <= handshake;
			// Outputs parked until every bank is done
			if (bank_all_done != '1) begin
				check_value("hsync", hsync, 1);
				check_value("vsync", vsync, 1);
				check_value("red", red, 0);
				check_value("green", green, 0);
				check_value("blue", blue, 0);
				check_value("active_video", active_video, 0);
			end
			// Frame capture in raster order
			if (active_video && frame_q.size() < FRAME_PIXELS) begin
				frame_q.push_back({red, green, blue});
			end
			// Active line length
			if (active_video) begin
				act_run++;
			end else if (act_prev) begin
				check_value("active line length", act_run, H_PIXELS);
				act_run = 0;
				lines_active++;
			end
			// hsync width and period
			if (!hsync) hs_low++;
			if (hsync && !hsync_prev) begin
				check_value("hsync low width", hs_low, 3);
				hs_low = 0;
			end
			if (!hsync && hsync_prev) begin
				if (last_hfall >= 0) begin
					check_value("hsync period", cycle_cnt - last_hfall, H_PERIOD);
				end
				last_hfall = cycle_cnt;
			end
			// vsync one line wide, after eight active lines
			if (!vsync) vs_low++;
			if (vsync && !vsync_prev) begin
				check_value("vsync low width", vs_low, H_PERIOD);
				vs_low = 0;
				vs_rises++;
			end
			if (!vsync && vsync_prev) begin
				check_value("active lines per frame", lines_active, V_LINES);
				lines_active = 0;
			end
			act_prev <= active_video;
			hsync_prev <= hsync;
			vsync_prev <= vsync;
		end
	end

	////////////////////////////////////////
	// Stimulus and frame check
	////////////////////////////////////////

	initial begin
		logic [7:0] color;
		logic [23:0] got;
		int bank;
		int idx;
		reset = 1'b1;
		iter_done = '0;
		bank_all_done = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			iter_count[b] = '0;
			hs_count[b] = 0;
		end
		void'($urandom(32'h54cf));
		// Each bank starts in its own quarter of the table
		for (int b = 0; b < NUM_BANKS; b++) begin
			bank_offset[b] = b * (TBL_SIZE / NUM_BANKS) + $urandom % (TBL_SIZE / NUM_BANKS);
		end
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		// Quiet while no done is offered
		repeat (4) begin
			@(negedge clk);
			check_value("handshake idle", handshake, '0);
		end
		// One count per bank per round
		for (int k = 0; k < BANK_DEPTH; k++) begin
			@(posedge clk);
			#1;
			for (int b = 0; b < NUM_BANKS; b++) begin
				iter_count[b] = STIM_TBL[(k + bank_offset[b]) % TBL_SIZE].count;
			end
			iter_done = '1;
			wait_handshake();
			@(posedge clk);
			#1;
			iter_done = '0;
		end
		@(posedge clk);
		#1;
		bank_all_done = '1;
		wait_frame();
		// Position b*32+k holds the k-th count of bank b
		for (int pos = 0; pos < FRAME_PIXELS; pos++) begin
			bank = pos / BANK_DEPTH;
			idx = ((pos % BANK_DEPTH) + bank_offset[bank]) % TBL_SIZE;
			color = STIM_TBL[idx].color;
			got = frame_q[pos];
			check_value($sformatf("red[%0d]", pos), got[23:16], {color[7:5], 5'd0});
			check_value($sformatf("green[%0d]", pos), got[15:8], {color[4:2], 5'd0});
			check_value($sformatf("blue[%0d]", pos), got[7:0], {color[1:0], 6'd0});
		end
		for (int b = 0; b < NUM_BANKS; b++) begin
			check_value($sformatf("handshake count[%0d]", b), hs_count[b], BANK_DEPTH);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== hw/mandel_display_top.sv ====
`timescale 1ns/1ps

module mandel_display_top
	import pixel_pkg::*;
	import video_pkg::*;
#(
	parameter int H_PIXELS = 640,
	parameter int V_LINES = 480,
	parameter int H_FRONT = 16,
	parameter int H_PULSE = 96,
	parameter int H_BACK = 48,
	parameter int V_FRONT = 10,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 33,
	parameter int NUM_BANKS = 10,
	parameter int MAX_ITER = 100
) (
	input logic M10k_pll,
	input logic reset,
	input iter_count_t iter_count [NUM_BANKS],
	input logic [NUM_BANKS-1:0] iter_done,
	input logic [NUM_BANKS-1:0] bank_all_done,
	output logic [NUM_BANKS-1:0] handshake,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic active_video
);

	// Producer to buffer
	bank_write_t bank_wr [NUM_BANKS];
	// Scanout read request and returned color
	coord_t next_x;
	coord_t next_y;
	color_word_t pixel;
	logic frame_ready;

	pixel_writer #(
		.NUM_BANKS(NUM_BANKS),
		.MAX_ITER(MAX_ITER)
	) i_pixel_writer (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.iter_count(iter_count),
		.iter_done(iter_done),
		.bank_all_done(bank_all_done),
		.handshake(handshake),
		.bank_wr(bank_wr),
		.frame_ready(frame_ready)
	);

	frame_buffer #(
		.H_PIXELS(H_PIXELS),
		.V_LINES(V_LINES),
		.NUM_BANKS(NUM_BANKS)
	) i_frame_buffer (
		.M10k_pll(M10k_pll),
		.bank_wr(bank_wr),
		.next_x(next_x),
		.next_y(next_y),
		.pixel(pixel)
	);

	vga_scanout #(
		.H_PIXELS(H_PIXELS),
		.V_LINES(V_LINES),
		.H_FRONT(H_FRONT),
		.H_PULSE(H_PULSE),
		.H_BACK(H_BACK),
		.V_FRONT(V_FRONT),
		.V_PULSE(V_PULSE),
		.V_BACK(V_BACK)
	) i_vga_scanout (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.frame_ready(frame_ready),
		.pixel(pixel),
		.next_x(next_x),
		.next_y(next_y),
		.hsync(hsync),
		.vsync(vsync),
		.red(red),
		.green(green),
		.blue(blue),
		.active_video(active_video)
	);

endmodule

// ==== hw/vga_scanout.sv ====
`timescale 1ns/1ps

module vga_scanout
	import pixel_pkg::*;
	import video_pkg::*;
#(
	parameter int H_PIXELS = 640,
	parameter int V_LINES = 480,
	parameter int H_FRONT = 16,
	parameter int H_PULSE = 96,
	parameter int H_BACK = 48,
	parameter int V_FRONT = 10,
	parameter int V_PULSE = 2,
	parameter int V_BACK = 33
) (
	input logic M10k_pll,
	input logic reset,
	input logic frame_ready,
	input color_word_t pixel,
	output coord_t next_x,
	output coord_t next_y,
	output logic hsync,
	output logic vsync,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic active_video
);

	scan_phase_t h_phase;
	scan_phase_t v_phase;
	coord_t h_count;
	coord_t v_count;
	logic running;
	logic h_last;
	logic v_last;
	logic line_end;
	logic pix_active;
	logic active_d1;
	logic hsync_d1;
	logic vsync_d1;

	// Phase order wraps back to active
	function automatic scan_phase_t next_phase(input scan_phase_t ph);
		return scan_phase_t'(ph + 2'd1);
	endfunction

	// Length of each phase in pixel clocks
	function automatic coord_t h_len(input scan_phase_t ph);
		case (ph)
			PH_ACTIVE: return coord_t'(H_PIXELS);
			PH_FRONT: return coord_t'(H_FRONT);
			PH_PULSE: return coord_t'(H_PULSE);
			default: return coord_t'(H_BACK);
		endcase
	endfunction

	// Length of each phase in lines
	function automatic coord_t v_len(input scan_phase_t ph);
		case (ph)
			PH_ACTIVE: return coord_t'(V_LINES);
			PH_FRONT: return coord_t'(V_FRONT);
			PH_PULSE: return coord_t'(V_PULSE);
			default: return coord_t'(V_BACK);
		endcase
	endfunction

	////////////////////////////////////////
	// Timing machines
	////////////////////////////////////////

	assign h_last = (h_count == coord_t'(h_len(h_phase) - 1'b1));
	assign v_last = (v_count == coord_t'(v_len(v_phase) - 1'b1));
	// Last clock of the back porch closes the line
	assign line_end = (h_phase == PH_BACK) && h_last;

	// One cycle behind frame_ready so (0,0) lands after the rise
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			running <= 1'b0;
		end else begin
			running <= frame_ready;
		end
	end

	always_ff @(posedge M10k_pll) begin
		if (reset || !running) begin
			// Parked at the frame origin
			h_phase <= PH_ACTIVE;
			h_count <= '0;
			v_phase <= PH_ACTIVE;
			v_count <= '0;
		end else begin
			if (h_last) begin
				h_phase <= next_phase(h_phase);
				h_count <= '0;
			end else begin
				h_count <= h_count + 1'b1;
			end
			// Vertical steps once per line
			if (line_end) begin
				if (v_last) begin
					v_phase <= next_phase(v_phase);
					v_count <= '0;
				end else begin
					v_count <= v_count + 1'b1;
				end
			end
		end
	end

	// Read coordinates, zero while blanked
	assign next_x = (h_phase == PH_ACTIVE) ? h_count : '0;
	assign next_y = (v_phase == PH_ACTIVE) ? v_count : '0;
	assign pix_active = running && (h_phase == PH_ACTIVE) && (v_phase == PH_ACTIVE);

	////////////////////////////////////////
	// Output pipeline
	////////////////////////////////////////

	// Stage 1 matches the memory read, stage 2 the color register
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			active_d1 <= 1'b0;
			hsync_d1 <= 1'b1;
			vsync_d1 <= 1'b1;
			active_video <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			active_d1 <= pix_active;
			hsync_d1 <= (h_phase != PH_PULSE);
			vsync_d1 <= (v_phase != PH_PULSE);
			active_video <= active_d1;
			hsync <= hsync_d1;
			vsync <= vsync_d1;
			// rgb332 widened, low bits zero
			red <= active_d1 ? {pixel.rgb.red, 5'd0} : 8'd0;
			green <= active_d1 ? {pixel.rgb.green, 5'd0} : 8'd0;
			blue <= active_d1 ? {pixel.rgb.blue, 6'd0} : 8'd0;
		end
	end

	// Sync pulse sits in the blanking interval after the pipeline
	a_no_sync_in_active : assert property (
		@(posedge M10k_pll) disable iff (reset)
		!(active_video && !hsync)
	);

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer
	import pixel_pkg::*;
	import video_pkg::*;
#(
	parameter int H_PIXELS = 640,
	parameter int V_LINES = 480,
	parameter int NUM_BANKS = 10
) (
	input logic M10k_pll,
	input bank_write_t bank_wr [NUM_BANKS],
	input coord_t next_x,
	input coord_t next_y,
	output color_word_t pixel
);

	// Contiguous slice of the raster per bank
	localparam int BANK_DEPTH = (H_PIXELS * V_LINES) / NUM_BANKS;
	localparam int MEM_AW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
	localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

	logic [ADDR_W-1:0] rd_pos;
	logic [ADDR_W-1:0] rd_addr;
	logic [BANK_SEL_W-1:0] bank_sel;
	logic [BANK_SEL_W-1:0] bank_sel_q;
	color_word_t bank_q [NUM_BANKS];

	////////////////////////////////////////
	// Read addressing
	////////////////////////////////////////

	// Raster position of the requested pixel
	assign rd_pos = ADDR_W'(next_y) * ADDR_W'(H_PIXELS) + ADDR_W'(next_x);

	// Highest bank whose base is at or below the position
	always_comb begin
		bank_sel = '0;
		for (int b = 1; b < NUM_BANKS; b++) begin
			if (rd_pos >= ADDR_W'(b * BANK_DEPTH)) begin
				bank_sel = BANK_SEL_W'(b);
			end
		end
	end

	// Offset within the selected bank
	assign rd_addr = rd_pos - ADDR_W'(bank_sel * BANK_DEPTH);

	// Select follows the data through the read register
	always_ff @(posedge M10k_pll) begin
		bank_sel_q <= bank_sel;
	end

	assign pixel = bank_q[bank_sel_q];

	////////////////////////////////////////
	// Memory banks
	////////////////////////////////////////

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		color_word_t mem [BANK_DEPTH];
		color_word_t q;

		// Own write port, shared read address
		always_ff @(posedge M10k_pll) begin
			if (bank_wr[b].we) begin
				mem[bank_wr[b].addr[MEM_AW-1:0]] <= bank_wr[b].data;
			end
			q <= mem[rd_addr[MEM_AW-1:0]];
		end

		assign bank_q[b] = q;

		// Writer count must stay inside its slice
		a_wr_in_range : assert property (
			@(posedge M10k_pll)
			bank_wr[b].we |-> (bank_wr[b].addr < ADDR_W'(BANK_DEPTH))
		);
	end

endmodule

// ==== hw/pixel_writer.sv ====
`timescale 1ns/1ps

module pixel_writer
	import pixel_pkg::*;
#(
	parameter int NUM_BANKS = 10,
	parameter int MAX_ITER = 100
) (
	input logic M10k_pll,
	input logic reset,
	input iter_count_t iter_count [NUM_BANKS],
	input logic [NUM_BANKS-1:0] iter_done,
	input logic [NUM_BANKS-1:0] bank_all_done,
	output logic [NUM_BANKS-1:0] handshake,
	output bank_write_t bank_wr [NUM_BANKS],
	output logic frame_ready
);

	// Two-state writer, one accept per two cycles
	typedef enum logic {
		WR_IDLE = 1'b0,
		WR_GAP = 1'b1
	} writer_state_t;

	// All banks finished, scanout may start
	assign frame_ready = &bank_all_done;

	////////////////////////////////////////
	// Per-bank writers
	////////////////////////////////////////

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_writer
		writer_state_t state;
		logic hs_q;
		logic wr_we;
		logic [ADDR_W-1:0] wr_addr;
		logic [ADDR_W-1:0] addr_cnt;
		color_word_t wr_data;
		logic accept;

		// Count taken only while idle and bank still busy
		assign accept = (state == WR_IDLE) && iter_done[b] && !bank_all_done[b];

		// Control path
		always_ff @(posedge M10k_pll) begin
			if (reset) begin
				state <= WR_IDLE;
				hs_q <= 1'b0;
				wr_we <= 1'b0;
				wr_addr <= '0;
				addr_cnt <= '0;
			end else begin
				case (state)
					WR_IDLE: begin
						if (accept) begin
							// Handshake and write go out together next cycle
							state <= WR_GAP;
							hs_q <= 1'b1;
							wr_we <= 1'b1;
							wr_addr <= addr_cnt;
							addr_cnt <= addr_cnt + 1'b1;
						end
					end
					default: begin
						// Gap cycle, done not sampled here
						state <= WR_IDLE;
						hs_q <= 1'b0;
						wr_we <= 1'b0;
					end
				endcase
			end
		end

		// Color register, loaded on accept only
		always_ff @(posedge M10k_pll) begin
			if (accept) begin
				wr_data <= color_map(iter_count[b], iter_count_t'(MAX_ITER));
			end
		end

		assign handshake[b] = hs_q;
		assign bank_wr[b] = '{we: wr_we, addr: wr_addr, data: wr_data};

		// Solver sees a single-cycle strobe per count
		a_handshake_pulse : assert property (
			@(posedge M10k_pll) disable iff (reset)
			handshake[b] |=> !handshake[b]
		);
	end

endmodule

// ==== hw/video_pkg.sv ====
package video_pkg;

	////////////////////////////////////////
	// Scan types
	////////////////////////////////////////

	// Pixel column or line number, covers up to 1023
	typedef logic [9:0] coord_t;

	// Four phases of one timing axis, in scan order
	// Incrementing past the back porch wraps to active
	typedef enum logic [1:0] {
		PH_ACTIVE = 2'd0,
		// Blank before the pulse
		PH_FRONT = 2'd1,
		// Sync asserted, low on the wire
		PH_PULSE = 2'd2,
		// Blank after the pulse
		PH_BACK = 2'd3
	} scan_phase_t;

endpackage

// ==== hw/pixel_pkg.sv ====
package pixel_pkg;

	////////////////////////////////////////
	// Widths and basic types
	////////////////////////////////////////

	// Address width of one memory bank, wide enough for a full frame
	localparam int ADDR_W = 19;

	// Escape-time result from one solver
	typedef logic [31:0] iter_count_t;

	// Field view of a stored color, as the DAC side reads it
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// One byte, seen raw by the memory and as rgb by the scanout
	typedef union packed {
		logic [7:0] raw;
		rgb332_t rgb;
	} color_word_t;

	// Write port of one bank
	typedef struct packed {
		logic we;
		logic [ADDR_W-1:0] addr;
		color_word_t data;
	} bank_write_t;

	////////////////////////////////////////
	// Color map
	////////////////////////////////////////

	// Thresholds from the top, each a power-of-two fraction of max_iter
	function automatic color_word_t color_map(input iter_count_t count, input iter_count_t max_iter);
		color_word_t color;
		if (count >= max_iter) begin
			// Inside the set
			color.raw = 8'h00;
		end else if (count >= (max_iter >> 1)) begin
			color.raw = 8'h64;
		end else if (count >= (max_iter >> 2)) begin
			color.raw = 8'h64;
		end else if (count >= (max_iter >> 3)) begin
			color.raw = 8'hA9;
		end else if (count >= (max_iter >> 4)) begin
			color.raw = 8'h65;
		end else if (count >= (max_iter >> 5)) begin
			color.raw = 8'h25;
		end else if (count >= (max_iter >> 6)) begin
			color.raw = 8'h6A;
		end else begin
			// Fast escape, background tone
			color.raw = 8'h52;
		end
		return color;
	endfunction

endpackage
